//--- hw/fetchPkg.sv
// Shared definitions for the fetch and decode front end
// Widths, opcode encodings, the bubble word, destination and immediate select codes
// and the instruction word type with its R, I and J views
// Modules import it inside their body and use scoped names in their port lists

package fetchPkg;

    // Datapath widths
    localparam int instrW   = 16;
    localparam int regAddrW = 3;
    localparam int opcW     = 5;

    // Instruction memory geometry with one entry per 16-bit word
    localparam int memAddrW = 8;
    localparam int memWords = 1 << memAddrW;

    // Bubble inserted on a stall with opNop in the opcode field
    localparam logic [instrW-1:0] nopInstr = 16'h0800;

    // Opcodes in bits 15:11 of the instruction
    localparam logic [opcW-1:0] opHalt  = 5'b00000;
    localparam logic [opcW-1:0] opNop   = 5'b00001;
    localparam logic [opcW-1:0] opJ     = 5'b00100;
    localparam logic [opcW-1:0] opJr    = 5'b00101;
    localparam logic [opcW-1:0] opJal   = 5'b00110;
    localparam logic [opcW-1:0] opJalr  = 5'b00111;
    localparam logic [opcW-1:0] opAddi  = 5'b01000;
    localparam logic [opcW-1:0] opSubi  = 5'b01001;
    localparam logic [opcW-1:0] opBeqz  = 5'b01100;
    localparam logic [opcW-1:0] opBnez  = 5'b01101;
    localparam logic [opcW-1:0] opSt    = 5'b10000;
    localparam logic [opcW-1:0] opLd    = 5'b10001;
    localparam logic [opcW-1:0] opAluR  = 5'b11011;  // Add, sub, xor, andn by funct

    // Destination register select
    localparam logic [1:0] destRs  = 2'b00;  // Bits 10:8
    localparam logic [1:0] destRdR = 2'b01;  // Bits 4:2
    localparam logic [1:0] destR7  = 2'b10;  // Link register
    localparam logic [1:0] destRdI = 2'b11;  // Bits 7:5

    // Immediate extension select for the immediate logic downstream
    localparam logic [2:0] immNone   = 3'd0;
    localparam logic [2:0] imm5Sext  = 3'd1;
    localparam logic [2:0] imm5Zext  = 3'd2;
    localparam logic [2:0] imm8Sext  = 3'd3;
    localparam logic [2:0] imm11Sext = 3'd4;

    // One instruction word seen three ways
    // The opcode sits in the same bits for every view
    typedef union packed {
        struct packed {
            logic [opcW-1:0]     opcode;
            logic [regAddrW-1:0] rs;
            logic [regAddrW-1:0] rt;
            logic [regAddrW-1:0] rd;
            logic [1:0]          funct;
        } rFmt;
        struct packed {
            logic [opcW-1:0]     opcode;
            logic [regAddrW-1:0] rs;
            logic [regAddrW-1:0] rd;
            logic [4:0]          imm;
        } iFmt;
        struct packed {
            logic [opcW-1:0] opcode;
            logic [10:0]     disp;
        } jFmt;
    } instrWord;

endpackage

//--- hw/progCounter.sv
// Program counter for the fetch stage
// Picks the next address from hold, branch, register jump, jump or sequential
// and registers it on the rising clock edge
// pc is a byte address and always steps by one 16-bit word

`timescale 1ns/10ps

module progCounter (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       stall,
    input  logic                       halt,
    input  logic                       pcSel,
    input  logic                       regJmp,
    input  logic                       jFlag,
    input  logic [fetchPkg::instrW-1:0] brnchAddr,
    input  logic [fetchPkg::instrW-1:0] imm,
    input  logic [fetchPkg::instrW-1:0] rs,
    output logic [fetchPkg::instrW-1:0] pc
);
    import fetchPkg::*;

    logic [instrW-1:0] pcInc;
    logic [instrW-1:0] nextPc;

    assign pcInc = pc + instrW'(2);

    // Hold beats every redirect
    always_comb begin
        if (halt || stall) begin
            nextPc = pc;
        end else if (pcSel) begin
            nextPc = brnchAddr;  // Resolved branch from later stage
        end else if (regJmp) begin
            nextPc = rs + imm;
        end else if (jFlag) begin
            nextPc = pcInc + imm;
        end else begin
            nextPc = pcInc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Targets from branch, jump and register jump must all be word aligned
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[0] == 1'b0)
        else $error("pc left word alignment: %h", pc);

endmodule

//--- hw/instrMem.sv
// Instruction memory, 256 words of 16 bits
// Read is combinational at the byte address pc, word index pc[8:1]
// The load port writes one word per clock while loadEn is high
// loadAddr is a word index, not a byte address

`timescale 1ns/10ps

module instrMem (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [fetchPkg::instrW-1:0] pc,
    input  logic                        loadEn,
    input  logic [fetchPkg::instrW-1:0] loadAddr,
    input  logic [fetchPkg::instrW-1:0] loadData,
    output logic [fetchPkg::instrW-1:0] rawInstr
);
    import fetchPkg::*;

    logic [instrW-1:0] mem [memWords];

    // Program load
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr[memAddrW-1:0]] <= loadData;
        end
    end

    assign rawInstr = mem[pc[memAddrW:1]];  // Drop byte offset

    // Program must cover every address the PC reaches once running
    fetchKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(rawInstr))
        else $error("Unknown instruction fetched at pc %h", pc);

endmodule

//--- hw/ctrlDecode.sv
// Opcode decoder for the fetch stage
// Turns one instruction word into the control levels for the later stages,
// the source-use flags for hazard checking and the destination register
// Instantiated twice at the top, once on the raw word and once on the issued word

`timescale 1ns/10ps

module ctrlDecode (
    input  fetchPkg::instrWord            instr,
    output logic                          regWrite,
    output logic                          memEnable,
    output logic                          memWr,
    output logic                          val2Reg,
    output logic                          aluSel,
    output logic                          regJmp,
    output logic                          jFlag,
    output logic                          bFlag,
    output logic                          halt,
    output logic                          ctrlErr,
    output logic                          readsRs,
    output logic                          readsRt,
    output logic [1:0]                    linkReg,
    output logic [2:0]                    immSel,
    output logic [fetchPkg::regAddrW-1:0] writeRegAddr,
    output logic                          valid
);
    import fetchPkg::*;

    logic [1:0] destSel;

    // linkReg is 01 for jal and 10 for jalr so writeback takes pc plus 2
    // aluSel high puts the immediate on the second ALU operand
    // val2Reg high writes back memory data
    always_comb begin
        regWrite  = 1'b0;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        regJmp    = 1'b0;
        jFlag     = 1'b0;
        bFlag     = 1'b0;
        halt      = 1'b0;
        ctrlErr   = 1'b0;
        readsRs   = 1'b0;
        readsRt   = 1'b0;
        linkReg   = 2'b00;
        immSel    = immNone;
        destSel   = destRdR;
        valid     = 1'b1;
        case (instr.rFmt.opcode)
            opHalt: halt = 1'b1;
            opNop:  valid = 1'b0;
            opAddi, opSubi: begin
                regWrite = 1'b1;
                aluSel   = 1'b1;
                readsRs  = 1'b1;
                immSel   = imm5Sext;
                destSel  = destRdI;
            end
            opSt: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;
                readsRs   = 1'b1;
                readsRt   = 1'b1;  // Store data comes from bits 7:5
                immSel    = imm5Sext;
            end
            opLd: begin
                memEnable = 1'b1;
                val2Reg   = 1'b1;
                regWrite  = 1'b1;
                aluSel    = 1'b1;
                readsRs   = 1'b1;
                immSel    = imm5Sext;
                destSel   = destRdI;
            end
            opBeqz, opBnez: begin
                bFlag   = 1'b1;  // Taken or not is resolved later
                readsRs = 1'b1;
                immSel  = imm8Sext;
            end
            opJ: begin
                jFlag  = 1'b1;
                immSel = imm11Sext;
            end
            opJr: begin
                regJmp  = 1'b1;
                readsRs = 1'b1;
                immSel  = imm8Sext;
            end
            opJal: begin
                jFlag    = 1'b1;
                regWrite = 1'b1;
                linkReg  = 2'b01;
                immSel   = imm11Sext;
                destSel  = destR7;
            end
            opJalr: begin
                regJmp   = 1'b1;
                regWrite = 1'b1;
                readsRs  = 1'b1;
                linkReg  = 2'b10;
                immSel   = imm8Sext;
                destSel  = destR7;
            end
            opAluR: begin
                regWrite = 1'b1;
                readsRs  = 1'b1;
                readsRt  = 1'b1;
            end
            default: begin
                // Illegal opcodes including exception entry and return
                ctrlErr = 1'b1;
                valid   = 1'b0;
            end
        endcase
    end

    // Destination address from the selected field
    always_comb begin
        case (destSel)
            destRs:  writeRegAddr = instr.iFmt.rs;
            destRdR: writeRegAddr = instr.rFmt.rd;
            destR7:  writeRegAddr = regAddrW'(7);
            destRdI: writeRegAddr = instr.iFmt.rd;
            default: writeRegAddr = instr.rFmt.rd;
        endcase
    end

    // Memory write only inside an enabled memory access
    wrNeedsEn: assert final (!(memWr && !memEnable))
        else $error("memWr without memEnable, opcode %b", instr.rFmt.opcode);

endmodule

//--- hw/hazardDetect.sv
// Read-after-write hazard detector for the fetch stage
// Keeps the destinations of the two instructions still in flight
// and raises nop when the fetched instruction reads one of them
// Slot one is filled from the issued instruction each clock, slot two ages from slot one

`timescale 1ns/10ps

module hazardDetect (
    input  logic                          clk,
    input  logic                          arstN,
    input  fetchPkg::instrWord            srcInstr,
    input  logic                          readsRs,
    input  logic                          readsRt,
    input  logic                          regWrite,
    input  logic [fetchPkg::regAddrW-1:0] writeRegAddr,
    output logic                          nop
);
    import fetchPkg::*;

    logic [1:0]               slotVld;   // Index 0 is slot one
    logic [1:0][regAddrW-1:0] slotAddr;
    logic                     rsHit;
    logic                     rtHit;

    // Match against any valid slot
    function automatic logic slotHit(input logic [regAddrW-1:0] src,
                                     input logic [1:0] vld,
                                     input logic [1:0][regAddrW-1:0] addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (vld[i] && addr[i] == src) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign rsHit = readsRs && slotHit(srcInstr.iFmt.rs, slotVld, slotAddr);
    assign rtHit = readsRt && slotHit(srcInstr.rFmt.rt, slotVld, slotAddr);
    assign nop   = rsHit || rtHit;

    // A bubble writes nothing, so a stalled reader drains the slots
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            slotVld <= 2'b00;
        end else begin
            slotVld <= {slotVld[0], regWrite};
        end
    end

    always_ff @(posedge clk) begin
        slotAddr[0] <= writeRegAddr;
        slotAddr[1] <= slotAddr[0];
    end

    // Stall only with something in flight
    nopNeedsSlot: assert property (@(posedge clk) disable iff (!arstN) nop |-> slotVld != 2'b00)
        else $error("nop raised with an empty scoreboard");

endmodule

//--- hw/fetchStage.sv
// Fetch and decode front end of the 16-bit teaching processor
// PC, instruction memory, hazard scoreboard and two decoders
// Decoder chk looks at the raw word for hazards, decoder cntrl drives the outputs
// On a hazard the issued word becomes the NOP bubble and the PC holds

`timescale 1ns/10ps

module fetchStage (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          loadEn,
    input  logic [fetchPkg::instrW-1:0]   loadAddr,
    input  logic [fetchPkg::instrW-1:0]   loadData,
    input  logic                          pcSel,
    input  logic [fetchPkg::instrW-1:0]   brnchAddr,
    input  logic [fetchPkg::instrW-1:0]   imm,
    input  logic [fetchPkg::instrW-1:0]   rs,
    output logic [fetchPkg::instrW-1:0]   pc,
    output fetchPkg::instrWord            instrOut,
    output logic                          regWrite,
    output logic [fetchPkg::regAddrW-1:0] writeRegAddr,
    output logic                          memEnable,
    output logic                          memWr,
    output logic                          val2Reg,
    output logic                          aluSel,
    output logic [2:0]                    immSel,
    output logic [1:0]                    linkReg,
    output logic                          ctrlErr,
    output logic                          bFlag,
    output logic                          jFlag,
    output logic                          regJmp,
    output logic                          halt,
    output logic                          valid
);
    import fetchPkg::*;

    logic [instrW-1:0] rawInstr;
    instrWord          issueInstr;
    logic              nop;
    logic              chkReadsRs;
    logic              chkReadsRt;

    progCounter progCounter_i (
        .clk(clk), .arstN(arstN), .stall(nop), .halt(halt), .pcSel(pcSel),
        .regJmp(regJmp), .jFlag(jFlag), .brnchAddr(brnchAddr), .imm(imm),
        .rs(rs), .pc(pc)
    );

    instrMem instrMem_i (
        .clk(clk), .arstN(arstN), .pc(pc), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .rawInstr(rawInstr)
    );

    // Only the source-use flags matter here
    ctrlDecode chk (
        .instr(rawInstr), .regWrite(), .memEnable(), .memWr(), .val2Reg(),
        .aluSel(), .regJmp(), .jFlag(), .bFlag(), .halt(), .ctrlErr(),
        .readsRs(chkReadsRs), .readsRt(chkReadsRt), .linkReg(), .immSel(),
        .writeRegAddr(), .valid()
    );

    hazardDetect hazardDetect_i (
        .clk(clk), .arstN(arstN), .srcInstr(rawInstr), .readsRs(chkReadsRs),
        .readsRt(chkReadsRt), .regWrite(regWrite), .writeRegAddr(writeRegAddr),
        .nop(nop)
    );

    assign issueInstr = nop ? nopInstr : rawInstr;  // Bubble on hazard
    assign instrOut   = issueInstr;

    ctrlDecode cntrl (
        .instr(issueInstr), .regWrite(regWrite), .memEnable(memEnable), .memWr(memWr),
        .val2Reg(val2Reg), .aluSel(aluSel), .regJmp(regJmp), .jFlag(jFlag),
        .bFlag(bFlag), .halt(halt), .ctrlErr(ctrlErr), .readsRs(), .readsRt(),
        .linkReg(linkReg), .immSel(immSel), .writeRegAddr(writeRegAddr), .valid(valid)
    );

endmodule

//--- verif/tbFetchStage.sv
// Testbench for the fetch and decode front end
// Loads the program from the data file while reset is held, then plays one stimulus
// line per cycle and compares pc, the issued word, the destination and the controls
// Run from the project root with the tb.f file list

`timescale 1ns/10ps

module tbFetchStage;
    import fetchPkg::*;

    localparam int  ctrlW      = 16;
    localparam int  dataWords  = 512;
    localparam int  lineWords  = 8;     // Columns per cycle line
    localparam int  maxCycles  = 64;
    localparam int  haltWait   = 16;
    localparam real checkDelay = 1.5;   // From falling edge to just before rising edge

    logic                clk;
    logic                arstN;
    logic                loadEn;
    logic [instrW-1:0]   loadAddr;
    logic [instrW-1:0]   loadData;
    logic                pcSel;
    logic [instrW-1:0]   brnchAddr;
    logic [instrW-1:0]   imm;
    logic [instrW-1:0]   rs;
    logic [instrW-1:0]   pc;
    instrWord            instrOut;
    logic                regWrite;
    logic [regAddrW-1:0] writeRegAddr;
    logic                memEnable;
    logic                memWr;
    logic                val2Reg;
    logic                aluSel;
    logic [2:0]          immSel;
    logic [1:0]          linkReg;
    logic                ctrlErr;
    logic                bFlag;
    logic                jFlag;
    logic                regJmp;
    logic                halt;
    logic                valid;
    logic [ctrlW-1:0]    ctrlVec;

    logic [instrW-1:0] tdata [dataWords];

    fetchStage fetchStage_i (
        .clk(clk), .arstN(arstN), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .pcSel(pcSel), .brnchAddr(brnchAddr), .imm(imm), .rs(rs),
        .pc(pc), .instrOut(instrOut), .regWrite(regWrite), .writeRegAddr(writeRegAddr),
        .memEnable(memEnable), .memWr(memWr), .val2Reg(val2Reg), .aluSel(aluSel),
        .immSel(immSel), .linkReg(linkReg), .ctrlErr(ctrlErr), .bFlag(bFlag),
        .jFlag(jFlag), .regJmp(regJmp), .halt(halt), .valid(valid)
    );

    // Same bit order as the last column of the data file
    assign ctrlVec = {regWrite, memEnable, memWr, val2Reg, aluSel, immSel, linkReg,
                      ctrlErr, bFlag, jFlag, regJmp, halt, valid};

    always #2 clk = ~clk;  // 4 ns period

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [instrW-1:0] exp,
                             input logic [instrW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkInstr(input string name, input instrWord exp, input instrWord act);
        if (act !== exp) begin
            abortRun($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic checkReg(input string name, input logic [regAddrW-1:0] exp,
                            input logic [regAddrW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("error %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic checkCtrl(input string name, input logic [ctrlW-1:0] exp,
                             input logic [ctrlW-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    initial begin
        int progWords;
        int numCycles;
        int base;
        int idx;
        int waited;

        clk       = 1'b0;
        arstN     = 1'b0;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        pcSel     = 1'b0;
        brnchAddr = '0;
        imm       = '0;
        rs        = '0;

        $readmemh("verif/fetchTestdata.txt", tdata);
        if ($isunknown({tdata[0], tdata[1]})) begin
            abortRun("The test data file is missing or has no header line");
        end
        progWords = tdata[0];
        numCycles = tdata[1];
        if (progWords > memWords) begin
            abortRun("The test data file holds more program words than the memory");
        end
        if (numCycles > maxCycles) begin
            abortRun("The test data file holds more cycle lines than the cycle limit");
        end

        // Program load through the write port while reset holds the PC
        for (int i = 0; i < progWords; i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = instrW'(i);
            loadData = tdata[2 + i];
        end
        @(negedge clk);
        loadEn = 1'b0;
        repeat (2) @(negedge clk);
        arstN = 1'b1;

        base = 2 + progWords;
        for (int n = 0; n < numCycles; n++) begin
            idx       = base + n * lineWords;
            pcSel     = tdata[idx][0];
            brnchAddr = tdata[idx + 1];
            imm       = tdata[idx + 2];
            rs        = tdata[idx + 3];
            #(checkDelay);
            checkWord($sformatf("cycle %0d pc", n), tdata[idx + 4], pc);
            checkInstr($sformatf("cycle %0d instrOut", n), tdata[idx + 5], instrOut);
            checkReg($sformatf("cycle %0d writeRegAddr", n),
                     tdata[idx + 6][regAddrW-1:0], writeRegAddr);
            checkCtrl($sformatf("cycle %0d controls", n), tdata[idx + 7], ctrlVec);
            @(negedge clk);
        end

        // Program ends in a halt
        waited = 0;
        while (halt !== 1'b1) begin
            if (waited == haltWait) begin
                abortRun("The DUT never raised halt after the last stimulus line");
            end
            @(negedge clk);
            waited++;
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verif/fetchTestdata.txt
// Header: program word count, cycle line count. Then the program, word 0 first
// Cycle lines: pcSel brnchAddr imm rs | expected pc instrOut writeRegAddr controls
0014 0013
4021 4EA2 8263 8A84 6605
D9F9 4067 4341 2003 0800
2002 0800 0800 3001 0800
2D04 0800 0800 F81C 0000
// Sequential fetch through each opcode class
0000 0000 0000 0000  0000 4021 0001 8901
0000 0000 0000 0000  0002 4EA2 0005 8901
0000 0000 0000 0000  0004 8263 0000 6901
0000 0000 0000 0000  0006 8A84 0004 D901
0000 0000 0000 0000  0008 6605 0001 0311
0000 0000 0000 0000  000A D9F9 0006 8001
// addi r3 then a reader of r3, two bubbles
0000 0000 0000 0000  000C 4067 0003 8901
0000 0000 0000 0000  000E 0800 0000 0000
0000 0000 0000 0000  000E 0800 0000 0000
0000 0000 0000 0000  000E 4341 0002 8901
// Branch over a decoded jump, then j, jal, jr
0001 0014 0040 0000  0010 2003 0000 0409
0000 0000 0004 0000  0014 2002 0000 0409
0000 0000 0002 0000  001A 3001 0007 8449
0000 0000 0004 0020  001E 2D04 0001 0305
// Illegal opcode, then halt holds even with pcSel
0000 0000 0000 0000  0024 F81C 0007 0020
0000 0000 0000 0000  0026 0000 0000 0003
0001 0010 0000 0000  0026 0000 0000 0003
0001 0010 0000 0000  0026 0000 0000 0003
0000 0000 0000 0000  0026 0000 0000 0003

//--- tb.f
hw/fetchPkg.sv
hw/progCounter.sv
hw/instrMem.sv
hw/ctrlDecode.sv
hw/hazardDetect.sv
hw/fetchStage.sv
verif/tbFetchStage.sv

//--- Bender.yml
package:
  name: fetchStage

sources:
  - files:
      - hw/fetchPkg.sv
      - hw/progCounter.sv
      - hw/instrMem.sv
      - hw/ctrlDecode.sv
      - hw/hazardDetect.sv
      - hw/fetchStage.sv
  - target: test
    files:
      - verif/tbFetchStage.sv
